// ==== sim.f ====
+incdir+src
src/lsu_pkg.sv
src/sb_if.sv
src/load_extract.sv
src/store_buffer.sv
src/load_store_unit.sv
src/mem_subsystem_top.sv
verification/tb_mem_model.sv
verification/tb_mem_subsystem.sv

// ==== src/load_extract.sv ====
module load_extract (
    input  lsu_pkg::word_t   word_i,
    input  logic [1:0]       offset_i,
    input  lsu_pkg::mem_op_e op_i,
    output lsu_pkg::word_t   data_o
);
    lsu_pkg::word_t shifted;

    // addressed byte moves down to bit 0
    assign shifted = word_i >> {offset_i, 3'b000};

    always_comb begin
        case (op_i)
            lsu_pkg::op_lb: begin
                data_o = {{24{shifted[7]}}, shifted[7:0]};
            end
            lsu_pkg::op_lbu: begin
                data_o = {24'd0, shifted[7:0]};
            end
            lsu_pkg::op_lh: begin
                data_o = {{16{shifted[15]}}, shifted[15:0]};
            end
            lsu_pkg::op_lhu: begin
                data_o = {16'd0, shifted[15:0]};
            end
            default: begin
                data_o = shifted;
            end
        endcase
    end

endmodule

// ==== src/load_store_unit.sv ====
module load_store_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             op_valid_i,
    output logic             op_ready_o,
    input  lsu_pkg::mem_op_e op_i,
    input  lsu_pkg::word_t   base_i,
    input  lsu_pkg::word_t   imm_i,
    input  lsu_pkg::word_t   store_data_i,
    input  lsu_pkg::tag_t    tag_i,
    output logic             res_valid_o,
    input  logic             res_ready_i,
    output lsu_pkg::tag_t    res_tag_o,
    output lsu_pkg::word_t   res_data_o,
    output lsu_pkg::word_t   dmem_addr_o,
    output lsu_pkg::bmask_t  dmem_rmask_o,
    output lsu_pkg::bmask_t  dmem_wmask_o,
    output lsu_pkg::word_t   dmem_wdata_o,
    input  lsu_pkg::word_t   dmem_rdata_i,
    input  logic             dmem_resp_i,
    sb_if.ctrl               sb
);
    lsu_pkg::lsu_state_e state_q;
    lsu_pkg::lsu_state_e state_d;
    lsu_pkg::word_t      ea;
    lsu_pkg::word_t      word_addr;
    lsu_pkg::bmask_t     size_mask;
    lsu_pkg::bmask_t     byte_mask;
    lsu_pkg::word_t      addr_q;
    lsu_pkg::bmask_t     rmask_q;
    logic [1:0]          off_q;
    lsu_pkg::mem_op_e    op_q;
    lsu_pkg::word_t      ext_word;
    logic [1:0]          ext_off;
    lsu_pkg::mem_op_e    ext_op;
    lsu_pkg::word_t      ext_data;
    logic                is_store;
    logic                in_idle;
    logic                wr_busy;
    logic                accept;
    logic                load_accept;
    logic                fwd_take;
    logic                issue_rd;
    logic                issue_wr;
    logic                rd_done;

    assign ea        = base_i + imm_i;
    assign word_addr = {ea[31:2], 2'b00};

    always_comb begin
        case (op_i)
            lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_sb: size_mask = 4'b0001;
            lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    end

    assign byte_mask = size_mask << ea[1:0];
    assign is_store  = op_i inside {lsu_pkg::op_sb, lsu_pkg::op_sh, lsu_pkg::op_sw};
    assign in_idle   = (state_q == lsu_pkg::st_idle);
    assign wr_busy   = |dmem_wmask_o;

    // a pending write blocks acceptance until its response
    assign op_ready_o  = in_idle && !wr_busy && !(is_store && sb.full);
    assign accept      = op_valid_i && op_ready_o;
    assign load_accept = accept && !is_store;

    assign sb.push_valid   = accept && is_store;
    assign sb.push_addr    = word_addr;
    assign sb.push_wmask   = byte_mask;
    assign sb.push_wdata   = store_data_i << {ea[1:0], 3'b000};
    assign sb.lookup_addr  = in_idle ? word_addr : addr_q;
    assign sb.lookup_rmask = in_idle ? byte_mask : rmask_q;
    assign sb.pop          = wr_busy && dmem_resp_i;

    assign fwd_take = load_accept && sb.fwd_hit;
    assign issue_rd = (load_accept && !sb.fwd_hit && !sb.conflict) ||
                      (state_q == lsu_pkg::st_drain && !wr_busy && !sb.conflict);
    // idle background drain, or forced drain while the load conflicts
    assign issue_wr = (in_idle && !accept && !wr_busy && sb.head_valid) ||
                      (state_q == lsu_pkg::st_drain && !wr_busy && sb.conflict);
    assign rd_done  = (state_q == lsu_pkg::st_read) && dmem_resp_i;

    // forwarding uses live inputs, the memory path uses latched ones
    assign ext_word = (state_q == lsu_pkg::st_read) ? dmem_rdata_i : sb.fwd_data;
    assign ext_off  = in_idle ? ea[1:0] : off_q;
    assign ext_op   = in_idle ? op_i : op_q;

    load_extract u_ext (
        .word_i   (ext_word),
        .offset_i (ext_off),
        .op_i     (ext_op),
        .data_o   (ext_data)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            lsu_pkg::st_idle: begin
                if (load_accept) begin
                    if (sb.fwd_hit) begin
                        state_d = lsu_pkg::st_result;
                    end else if (sb.conflict) begin
                        state_d = lsu_pkg::st_drain;
                    end else begin
                        state_d = lsu_pkg::st_read;
                    end
                end
            end
            lsu_pkg::st_drain: begin
                if (issue_rd) begin
                    state_d = lsu_pkg::st_read;
                end
            end
            lsu_pkg::st_read: begin
                if (dmem_resp_i) begin
                    state_d = lsu_pkg::st_result;
                end
            end
            default: begin
                if (res_ready_i) begin
                    state_d = lsu_pkg::st_idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= lsu_pkg::st_idle;
            dmem_rmask_o <= '0;
            dmem_wmask_o <= '0;
            res_valid_o  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (dmem_resp_i) begin
                dmem_rmask_o <= '0;
                dmem_wmask_o <= '0;
            end
            if (issue_wr) begin
                dmem_wmask_o <= sb.head_wmask;
            end
            if (issue_rd) begin
                dmem_rmask_o <= sb.lookup_rmask;
            end
            if (fwd_take || rd_done) begin
                res_valid_o <= 1'b1;
            end else if (state_q == lsu_pkg::st_result && res_ready_i) begin
                res_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q    <= word_addr;
            rmask_q   <= byte_mask;
            off_q     <= ea[1:0];
            op_q      <= op_i;
            res_tag_o <= tag_i;
        end
        if (issue_rd) begin
            dmem_addr_o <= sb.lookup_addr;
        end else if (issue_wr) begin
            dmem_addr_o  <= sb.head_addr;
            dmem_wdata_o <= sb.head_wdata;
        end
        if (fwd_take || rd_done) begin
            res_data_o <= ext_data;
        end
    end

endmodule

// ==== src/lsu_params.svh ====
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// store buffer entries (2 or more)
`define LSU_SB_DEPTH 4

// result tag width
`define LSU_TAG_W 4

`endif

// ==== src/lsu_pkg.sv ====
`include "lsu_params.svh"

package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0] bmask_t;
    typedef logic [`LSU_TAG_W-1:0] tag_t;
    typedef logic [$clog2(`LSU_SB_DEPTH)-1:0] sb_ptr_t;

    // bit 3 marks a store, low bits follow funct3
    typedef enum logic [3:0] {
        op_lb  = 4'b0000,
        op_lh  = 4'b0001,
        op_lw  = 4'b0010,
        op_lbu = 4'b0100,
        op_lhu = 4'b0101,
        op_sb  = 4'b1000,
        op_sh  = 4'b1001,
        op_sw  = 4'b1010
    } mem_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_drain,
        st_read,
        st_result
    } lsu_state_e;

endpackage

// ==== src/mem_subsystem_top.sv ====
module mem_subsystem_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             op_valid_i,
    output logic             op_ready_o,
    input  lsu_pkg::mem_op_e op_i,
    input  lsu_pkg::word_t   base_i,
    input  lsu_pkg::word_t   imm_i,
    input  lsu_pkg::word_t   store_data_i,
    input  lsu_pkg::tag_t    tag_i,
    output logic             res_valid_o,
    input  logic             res_ready_i,
    output lsu_pkg::tag_t    res_tag_o,
    output lsu_pkg::word_t   res_data_o,
    output lsu_pkg::word_t   dmem_addr_o,
    output lsu_pkg::bmask_t  dmem_rmask_o,
    output lsu_pkg::bmask_t  dmem_wmask_o,
    output lsu_pkg::word_t   dmem_wdata_o,
    input  lsu_pkg::word_t   dmem_rdata_i,
    input  logic             dmem_resp_i
);
    sb_if sb_bus ();

    load_store_unit u_lsu (
        .clk          (clk),
        .rst          (rst),
        .op_valid_i   (op_valid_i),
        .op_ready_o   (op_ready_o),
        .op_i         (op_i),
        .base_i       (base_i),
        .imm_i        (imm_i),
        .store_data_i (store_data_i),
        .tag_i        (tag_i),
        .res_valid_o  (res_valid_o),
        .res_ready_i  (res_ready_i),
        .res_tag_o    (res_tag_o),
        .res_data_o   (res_data_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_rmask_o (dmem_rmask_o),
        .dmem_wmask_o (dmem_wmask_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_resp_i  (dmem_resp_i),
        .sb           (sb_bus.ctrl)
    );

    store_buffer u_sb (
        .clk (clk),
        .rst (rst),
        .sb  (sb_bus.buffer)
    );

endmodule

// ==== src/sb_if.sv ====
interface sb_if;

    // push
    logic            push_valid;
    lsu_pkg::word_t  push_addr;
    lsu_pkg::bmask_t push_wmask;
    lsu_pkg::word_t  push_wdata;
    logic            full;

    // lookup answered combinationally
    lsu_pkg::word_t  lookup_addr;
    lsu_pkg::bmask_t lookup_rmask;
    logic            fwd_hit;
    lsu_pkg::word_t  fwd_data;
    logic            conflict;

    // drain
    logic            head_valid;
    lsu_pkg::word_t  head_addr;
    lsu_pkg::bmask_t head_wmask;
    lsu_pkg::word_t  head_wdata;
    logic            pop;

    modport ctrl (
        output push_valid, push_addr, push_wmask, push_wdata, lookup_addr, lookup_rmask, pop,
        input  full, fwd_hit, fwd_data, conflict, head_valid, head_addr, head_wmask, head_wdata
    );

    modport buffer (
        input  push_valid, push_addr, push_wmask, push_wdata, lookup_addr, lookup_rmask, pop,
        output full, fwd_hit, fwd_data, conflict, head_valid, head_addr, head_wmask, head_wdata
    );

endinterface

// ==== src/store_buffer.sv ====
`include "lsu_params.svh"

module store_buffer (
    input  logic clk,
    input  logic rst,
    sb_if.buffer sb
);
    localparam int DEPTH = `LSU_SB_DEPTH;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic             valid_q [DEPTH];
    lsu_pkg::word_t   addr_q  [DEPTH];
    lsu_pkg::bmask_t  wmask_q [DEPTH];
    lsu_pkg::word_t   wdata_q [DEPTH];
    lsu_pkg::sb_ptr_t head_q;
    lsu_pkg::sb_ptr_t tail_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    function automatic lsu_pkg::sb_ptr_t next_ptr(input lsu_pkg::sb_ptr_t p);
        if (int'(p) == DEPTH - 1) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign sb.full = (count_q == CNT_W'(DEPTH));
    assign do_push = sb.push_valid && !sb.full;
    assign do_pop  = sb.pop && valid_q[head_q];

    assign sb.head_valid = valid_q[head_q];
    assign sb.head_addr  = addr_q[head_q];
    assign sb.head_wmask = wmask_q[head_q];
    assign sb.head_wdata = wdata_q[head_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                valid_q[i] <= 1'b0;
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                valid_q[tail_q] <= 1'b1;
                tail_q <= next_ptr(tail_q);
            end
            if (do_pop) begin
                valid_q[head_q] <= 1'b0;
                head_q <= next_ptr(head_q);
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            addr_q[tail_q]  <= sb.push_addr;
            wmask_q[tail_q] <= sb.push_wmask;
            wdata_q[tail_q] <= sb.push_wdata;
        end
    end

    // search runs oldest to youngest so the last match wins
    always_comb begin : search
        int   idx;
        logic match;
        match       = 1'b0;
        sb.fwd_hit  = 1'b0;
        sb.fwd_data = '0;
        for (int i = 0; i < DEPTH; i++) begin
            idx = (int'(head_q) + i) % DEPTH;
            if (valid_q[idx] && (addr_q[idx] == sb.lookup_addr)) begin
                match       = 1'b1;
                sb.fwd_hit  = ((wmask_q[idx] & sb.lookup_rmask) == sb.lookup_rmask);
                sb.fwd_data = wdata_q[idx];
            end
        end
        sb.conflict = match && !sb.fwd_hit;
    end

endmodule

// ==== verification/tb_mem_model.sv ====
package tb_mem_model;

    localparam int WINDOW = 32;

    logic [7:0] bytes_q [WINDOW];

    // every address bit feeds the pattern
    function automatic logic [7:0] fill_byte(input int addr);
        return 8'(addr * 37 + 11) ^ 8'(addr >> 3);
    endfunction

    function automatic void reset_model();
        for (int a = 0; a < WINDOW; a++) begin
            bytes_q[a] = fill_byte(a);
        end
    endfunction

    function automatic int size_of(input lsu_pkg::mem_op_e op);
        case (op)
            lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_sb: return 1;
            lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic bit is_store(input lsu_pkg::mem_op_e op);
        return op inside {lsu_pkg::op_sb, lsu_pkg::op_sh, lsu_pkg::op_sw};
    endfunction

    function automatic void apply_store(input int ea, input lsu_pkg::mem_op_e op,
                                        input lsu_pkg::word_t data);
        for (int i = 0; i < size_of(op); i++) begin
            bytes_q[ea + i] = data[8*i +: 8];
        end
    endfunction

    // little endian bytes, then sign or zero fill
    function automatic lsu_pkg::word_t predict_load(input int ea, input lsu_pkg::mem_op_e op);
        lsu_pkg::word_t v;
        v = '0;
        for (int i = 0; i < size_of(op); i++) begin
            v[8*i +: 8] = bytes_q[ea + i];
        end
        if (op == lsu_pkg::op_lb && v[7]) begin
            v[31:8] = '1;
        end
        if (op == lsu_pkg::op_lh && v[15]) begin
            v[31:16] = '1;
        end
        return v;
    endfunction

endpackage

// ==== verification/tb_mem_subsystem.sv ====
`include "lsu_params.svh"

module tb_mem_subsystem;

    localparam int N_OPS = 2 + 25 + 2 + (`LSU_SB_DEPTH + 2) + 40 + 300;
    localparam int MAX_CYCLES = N_OPS * 40;

    logic             clk = 1'b0;
    logic             rst;
    logic             op_valid_i;
    logic             op_ready_o;
    lsu_pkg::mem_op_e op_i;
    lsu_pkg::word_t   base_i;
    lsu_pkg::word_t   imm_i;
    lsu_pkg::word_t   store_data_i;
    lsu_pkg::tag_t    tag_i;
    logic             res_valid_o;
    logic             res_ready_i = 1'b1;
    lsu_pkg::tag_t    res_tag_o;
    lsu_pkg::word_t   res_data_o;
    lsu_pkg::word_t   dmem_addr_o;
    lsu_pkg::bmask_t  dmem_rmask_o;
    lsu_pkg::bmask_t  dmem_wmask_o;
    lsu_pkg::word_t   dmem_wdata_o;
    lsu_pkg::word_t   dmem_rdata_i = '0;
    logic             dmem_resp_i = 1'b0;

    lsu_pkg::word_t   dmem_q [8];
    lsu_pkg::tag_t    exp_tag_q [$];
    lsu_pkg::word_t   exp_val_q [$];
    lsu_pkg::word_t   exp_waddr_q [$];
    lsu_pkg::bmask_t  exp_wmask_q [$];
    lsu_pkg::word_t   exp_wdata_q [$];
    lsu_pkg::word_t   exp_raddr = '0;
    lsu_pkg::bmask_t  exp_rmask = '0;
    lsu_pkg::mem_op_e all_ops [8];
    lsu_pkg::tag_t    next_tag;
    lsu_pkg::tag_t    held_tag;
    lsu_pkg::word_t   held_data;
    int               errors = 0;
    int               tests_run = 0;
    int               tests_failed = 0;
    int               test_err_start = 0;
    int               cycle = 0;
    int               acc_cycle = 0;
    int               last_latency = 0;
    int               delay = -1;
    logic             bp_en = 1'b0;
    logic             saw_stall = 1'b0;
    logic             prev_valid = 1'b0;
    logic             hold_q = 1'b0;

    mem_subsystem_top dut_i (.*);

    always #10 clk = ~clk;

    task automatic check_word(input string name, input lsu_pkg::word_t exp,
                              input lsu_pkg::word_t got);
        assert (got === exp) else begin
            $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    function automatic lsu_pkg::word_t byte_bits(input lsu_pkg::bmask_t m);
        lsu_pkg::word_t b;
        for (int i = 0; i < 4; i++) begin
            b[8*i +: 8] = {8{m[i]}};
        end
        return b;
    endfunction

    // writes must leave in the order the stores were accepted
    task automatic answer_request();
        int             idx;
        lsu_pkg::word_t bits;
        idx  = int'(dmem_addr_o[4:2]);
        bits = byte_bits(dmem_wmask_o);
        assert (dmem_addr_o < 32) else begin
            $display("error at %0t: dmem request outside the test window", $time);
            errors++;
        end
        if (dmem_wmask_o != '0) begin
            assert (exp_waddr_q.size() != 0) else begin
                $display("error at %0t: dmem write with no store left to drain", $time);
                errors++;
            end
            if (exp_waddr_q.size() != 0) begin
                check_word("dmem_addr_o", exp_waddr_q.pop_front(), dmem_addr_o);
                check_word("dmem_wmask_o", 32'(exp_wmask_q.pop_front()), 32'(dmem_wmask_o));
                check_word("dmem_wdata_o", exp_wdata_q.pop_front() & bits, dmem_wdata_o & bits);
            end
            dmem_q[idx] = (dmem_q[idx] & ~bits) | (dmem_wdata_o & bits);
        end else begin
            check_word("dmem_addr_o", exp_raddr, dmem_addr_o);
            check_word("dmem_rmask_o", 32'(exp_rmask), 32'(dmem_rmask_o));
            dmem_rdata_i = dmem_q[idx];
        end
    endtask

    always @(negedge clk) begin
        if (rst || dmem_resp_i) begin
            dmem_resp_i = 1'b0;
            delay = -1;
        end else if (dmem_rmask_o != '0 || dmem_wmask_o != '0) begin
            if (delay < 0) begin
                delay = $urandom_range(0, 3);
            end
            if (delay == 0) begin
                answer_request();
                dmem_resp_i = 1'b1;
            end else begin
                delay--;
            end
        end
    end

    always @(negedge clk) begin
        res_ready_i = bp_en ? 1'($urandom_range(0, 1)) : 1'b1;
    end

    task automatic take_result();
        assert (exp_tag_q.size() != 0) else begin
            $display("error at %0t: result returned with no load outstanding", $time);
            errors++;
        end
        if (exp_tag_q.size() != 0) begin
            check_word("res_tag_o", 32'(exp_tag_q.pop_front()), 32'(res_tag_o));
            check_word("res_data_o", exp_val_q.pop_front(), res_data_o);
        end
    endtask

    // outputs sampled on the rising edge before the DUT registers update
    always @(posedge clk) begin
        cycle++;
        if (cycle > MAX_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycle);
            $display("FAIL: see errors above");
            $finish;
        end else if (!rst) begin
            if (op_valid_i && op_ready_o && !tb_mem_model::is_store(op_i)) begin
                acc_cycle = cycle;
            end
            assert (!(res_valid_o && op_ready_o)) else begin
                $display("error at %0t: op_ready_o high while a result is pending", $time);
                errors++;
            end
            if (hold_q) begin
                assert (res_valid_o) else begin
                    $display("error at %0t: result dropped before it was taken", $time);
                    errors++;
                end
                check_word("res_tag_o", 32'(held_tag), 32'(res_tag_o));
                check_word("res_data_o", held_data, res_data_o);
            end
            if (res_valid_o && !prev_valid) begin
                last_latency = cycle - acc_cycle;
            end
            if (res_valid_o && res_ready_i) begin
                take_result();
            end
            hold_q     = res_valid_o && !res_ready_i;
            held_tag   = res_tag_o;
            held_data  = res_data_o;
            prev_valid = res_valid_o;
        end
    end

    task automatic run_op(input lsu_pkg::mem_op_e op, input int ea, input lsu_pkg::word_t data);
        lsu_pkg::word_t imm;
        int             off;
        int             n;
        imm = 32'($urandom_range(0, 63)) - 32'd32;
        off = ea % 4;
        n   = tb_mem_model::size_of(op);
        @(negedge clk);
        op_valid_i   = 1'b1;
        op_i         = op;
        imm_i        = imm;
        base_i       = 32'(ea) - imm;
        store_data_i = data;
        tag_i        = next_tag;
        @(posedge clk);
        while (!op_ready_o) begin
            saw_stall = saw_stall ||
                        (tb_mem_model::is_store(op) && exp_waddr_q.size() == `LSU_SB_DEPTH);
            @(posedge clk);
        end
        if (tb_mem_model::is_store(op)) begin
            tb_mem_model::apply_store(ea, op, data);
            exp_waddr_q.push_back(32'(ea - off));
            exp_wmask_q.push_back(4'(((1 << n) - 1) << off));
            exp_wdata_q.push_back(data << (8 * off));
        end else begin
            exp_raddr = 32'(ea - off);
            exp_rmask = 4'(((1 << n) - 1) << off);
            exp_tag_q.push_back(next_tag);
            exp_val_q.push_back(tb_mem_model::predict_load(ea, op));
        end
        next_tag++;
    endtask

    task automatic random_op();
        lsu_pkg::mem_op_e op;
        int               ea;
        op = all_ops[$urandom_range(0, 7)];
        ea = $urandom_range(0, 31) & ~(tb_mem_model::size_of(op) - 1);
        run_op(op, ea, $urandom());
    endtask

    task automatic sub_word_loads(input int word);
        for (int off = 0; off < 4; off++) begin
            run_op(lsu_pkg::op_lb, word + off, '0);
            run_op(lsu_pkg::op_lbu, word + off, '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            run_op(lsu_pkg::op_lh, word + off, '0);
            run_op(lsu_pkg::op_lhu, word + off, '0);
        end
    endtask

    // wait until every load has answered and every store reached memory
    task automatic settle();
        @(negedge clk);
        op_valid_i = 1'b0;
        while (exp_tag_q.size() != 0 || exp_waddr_q.size() != 0 || res_valid_o ||
               dmem_rmask_o != '0 || dmem_wmask_o != '0) begin
            @(negedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_err_start) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - test_err_start);
            tests_failed++;
        end
        test_err_start = errors;
    endtask

    initial begin
        void'($urandom(32'h59e2));
        all_ops = '{lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_lh, lsu_pkg::op_lhu,
                    lsu_pkg::op_lw, lsu_pkg::op_sb, lsu_pkg::op_sh, lsu_pkg::op_sw};
        rst          = 1'b1;
        op_valid_i   = 1'b0;
        op_i         = lsu_pkg::op_lw;
        base_i       = '0;
        imm_i        = '0;
        store_data_i = '0;
        tag_i        = '0;
        next_tag     = '0;
        tb_mem_model::reset_model();
        for (int a = 0; a < 32; a++) begin
            dmem_q[a / 4][8 * (a % 4) +: 8] = tb_mem_model::fill_byte(a);
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;

        run_op(lsu_pkg::op_sw, 16, $urandom());
        run_op(lsu_pkg::op_lw, 16, '0);
        settle();
        assert (last_latency == 1) else begin
            $display("error: forwarded load answered after %0d cycles, not 1", last_latency);
            errors++;
        end
        finish_test("word store then forwarded word load");

        // word 20 comes from memory, word 24 from the buffer
        sub_word_loads(20);
        run_op(lsu_pkg::op_sw, 24, $urandom());
        sub_word_loads(24);
        settle();
        finish_test("byte and halfword loads at every offset");

        run_op(lsu_pkg::op_sb, 28 + int'($urandom_range(0, 3)), $urandom());
        run_op(lsu_pkg::op_lw, 28, '0);
        settle();
        finish_test("byte store then word load of the same word");

        saw_stall = 1'b0;
        for (int i = 0; i < `LSU_SB_DEPTH + 2; i++) begin
            run_op(lsu_pkg::op_sw, 4 * (i % 8), $urandom());
        end
        settle();
        assert (saw_stall) else begin
            $display("error: op_ready_o never fell while the store buffer was full");
            errors++;
        end
        finish_test("stores beyond the buffer depth");

        bp_en = 1'b1;
        repeat (40) random_op();
        settle();
        finish_test("random result back-pressure");

        repeat (300) random_op();
        settle();
        repeat (10) @(negedge clk);
        for (int a = 0; a < 32; a++) begin
            check_word($sformatf("dmem byte %0d", a), 32'(tb_mem_model::bytes_q[a]),
                       32'(dmem_q[a / 4][8 * (a % 4) +: 8]));
        end
        finish_test("random mixed operations");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
